//--- files.f
hdl/mshr_cfg_pkg.sv
hdl/mshr_msg_pkg.sv
hdl/mshr_entry_bus_if.sv
hdl/mshr_entry.sv
hdl/mshr_entry_table.sv
hdl/mshr_rr_arb.sv
hdl/mshr_read_router.sv
hdl/mshr_top.sv
testbench/mshr_chk.sv
testbench/tb_mshr_top.sv

//--- Bender.yml
package:
  name: mshr

sources:
  - files:
      - hdl/mshr_cfg_pkg.sv
      - hdl/mshr_msg_pkg.sv
      - hdl/mshr_entry_bus_if.sv
      - hdl/mshr_entry.sv
      - hdl/mshr_entry_table.sv
      - hdl/mshr_rr_arb.sv
      - hdl/mshr_read_router.sv
      - hdl/mshr_top.sv
  - target: test
    files:
      - testbench/mshr_chk.sv
      - testbench/tb_mshr_top.sv

//--- testbench/tb_mshr_top.sv
`timescale 1ns/10ps

module tb_mshr_top;

    localparam int PERIOD   = 4;
    localparam int TEST_NUM = 6;
    localparam int N        = mshr_cfg_pkg::ENTRY_NUM;
    localparam int IW       = mshr_cfg_pkg::IDX_W;
    localparam int AW       = mshr_cfg_pkg::ADDR_W;

    // model entry states
    localparam int S_IDLE = 0, S_DS = 1, S_WLF = 2, S_RD = 3, S_WRD = 4, S_REL = 5;

    logic          clk, rst_n;
    logic          alloc_vld, stall, ds_req_vld, release_vld;
    logic [IW-1:0] alloc_idx, ds_req_idx, release_idx;
    logic          update_en, update_hit, ds_req_rdy, linefill_done, rd_done;
    logic [IW-1:0] update_idx, linefill_done_idx, rd_done_idx;
    logic [1:0]    update_dir;
    logic [AW-1:0] update_addr, ds_req_addr;
    logic [3:0]    rd_vld, rd_rdy;  // west, east, south, north
    logic [AW-1:0] rd_addr [4];
    logic [IW-1:0] rd_idx [4];

    // reference model
    int            m_state [N];
    logic [AW-1:0] m_addr [N];
    logic [1:0]    m_dir [N];
    int            ds_ptr, rd_ptr;
    int            ds_lock, rd_lock;  // -1 when no grant is held

    int            seed = 32'hd6d1_d520;
    int            err_cnt, errs_at_start, pass_tests;
    string         test_name;

    mshr_top uut (
        .*,
        .west_rd_vld  (rd_vld[0]), .west_rd_addr  (rd_addr[0]), .west_rd_idx  (rd_idx[0]),
        .west_rd_rdy  (rd_rdy[0]),
        .east_rd_vld  (rd_vld[1]), .east_rd_addr  (rd_addr[1]), .east_rd_idx  (rd_idx[1]),
        .east_rd_rdy  (rd_rdy[1]),
        .south_rd_vld (rd_vld[2]), .south_rd_addr (rd_addr[2]), .south_rd_idx (rd_idx[2]),
        .south_rd_rdy (rd_rdy[2]),
        .north_rd_vld (rd_vld[3]), .north_rd_addr (rd_addr[3]), .north_rd_idx (rd_idx[3]),
        .north_rd_rdy (rd_rdy[3])
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_NUM * 500 * PERIOD);
        $display("watchdog: run did not finish within %0d cycles", TEST_NUM * 500);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------
    // model helpers
    // ------------------------------
    function automatic int pick_grant(input logic [N-1:0] vld, input int ptr, input int lock);
        if (lock >= 0) return lock;  // stalled winner keeps the port
        for (int k = 0; k < N; k++) begin
            if (vld[(ptr + k) % N]) return (ptr + k) % N;
        end
        return -1;
    endfunction

    function automatic logic [N-1:0] in_state(input int st);
        logic [N-1:0] v;
        for (int i = 0; i < N; i++) v[i] = (m_state[i] == st);
        return v;
    endfunction

    function automatic logic [N-1:0] busy_vec();
        return in_state(S_DS) | in_state(S_WLF) | in_state(S_RD) | in_state(S_WRD);
    endfunction

    function automatic int lowest_free();
        logic [N-1:0] b;
        b = busy_vec();
        for (int i = 0; i < N; i++) begin
            if (!b[i]) return i;
        end
        return -1;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Fail %s: %s expected %0h, actual %0h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_outputs();
        int g;
        int r;
        int f;
        g = pick_grant(in_state(S_DS), ds_ptr, ds_lock);
        r = pick_grant(in_state(S_RD), rd_ptr, rd_lock);
        f = lowest_free();
        check_value("alloc_vld", f >= 0, alloc_vld);
        check_value("stall", f < 0, stall);
        if (f >= 0) check_value("alloc_idx", f, alloc_idx);
        check_value("ds_req_vld", g >= 0, ds_req_vld);
        if (g >= 0) begin
            check_value("ds_req_idx", g, ds_req_idx);
            check_value("ds_req_addr", m_addr[g], ds_req_addr);
        end
        for (int d = 0; d < 4; d++) begin
            check_value("rd_vld", r >= 0 && m_dir[r] == d, rd_vld[d]);
        end
        if (r >= 0) begin
            check_value("rd_addr", m_addr[r], rd_addr[m_dir[r]]);
            check_value("rd_idx", r, rd_idx[m_dir[r]]);
        end
        check_value("release_vld", |in_state(S_REL), release_vld);
        for (int i = 0; i < N; i++) begin
            if (m_state[i] == S_REL) check_value("release_idx", i, release_idx);
        end
    endtask

    task automatic advance_model();
        int g;
        int r;
        int nxt [N];
        g = pick_grant(in_state(S_DS), ds_ptr, ds_lock);
        r = pick_grant(in_state(S_RD), rd_ptr, rd_lock);
        foreach (m_state[i]) begin
            nxt[i] = m_state[i];
            case (m_state[i])
                S_IDLE, S_REL: begin
                    nxt[i] = S_IDLE;
                    if (update_en && update_idx == i) begin
                        nxt[i]    = update_hit ? S_RD : S_DS;
                        m_addr[i] = update_addr;
                        m_dir[i]  = update_dir;
                    end
                end
                S_DS:    if (g == i && ds_req_rdy) nxt[i] = S_WLF;
                S_WLF:   if (linefill_done && linefill_done_idx == i) nxt[i] = S_RD;
                S_RD:    if (r == i && rd_rdy[m_dir[i]]) nxt[i] = S_WRD;
                S_WRD:   if (rd_done && rd_done_idx == i) nxt[i] = S_REL;
                default: nxt[i] = S_IDLE;
            endcase
        end
        if (g >= 0 && ds_req_rdy) begin
            ds_ptr  = (g + 1) % N;
            ds_lock = -1;
        end else if (g >= 0) begin
            ds_lock = g;
        end
        if (r >= 0 && rd_rdy[m_dir[r]]) begin
            rd_ptr  = (r + 1) % N;
            rd_lock = -1;
        end else if (r >= 0) begin
            rd_lock = r;
        end
        m_state = nxt;
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic tick();
        @(posedge clk);
        advance_model();
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic clear_inputs();
        update_en         = 1'b0;
        update_idx        = '0;
        update_addr       = '0;
        update_dir        = '0;
        update_hit        = 1'b0;
        ds_req_rdy        = 1'b0;
        linefill_done     = 1'b0;
        linefill_done_idx = '0;
        rd_done           = 1'b0;
        rd_done_idx       = '0;
        rd_rdy            = '0;
    endtask

    task automatic push_request(input logic hit, input logic [1:0] dir);
        update_en   = 1'b1;
        update_idx  = lowest_free();
        update_addr = $random(seed);
        update_dir  = dir;
        update_hit  = hit;
        tick();
        update_en   = 1'b0;
    endtask

    // serve linefill and read done until every masked entry is free
    task automatic drain(input logic [N-1:0] mask);
        ds_req_rdy = 1'b1;
        rd_rdy     = 4'hf;
        for (int n = 0; n < 100 && |(mask & busy_vec()); n++) begin
            linefill_done = 1'b0;
            rd_done       = 1'b0;
            for (int i = N - 1; i >= 0; i--) begin
                if (mask[i] && m_state[i] == S_WLF) begin
                    linefill_done     = 1'b1;
                    linefill_done_idx = i;
                end
                if (mask[i] && m_state[i] == S_WRD) begin
                    rd_done     = 1'b1;
                    rd_done_idx = i;
                end
            end
            tick();
        end
        clear_inputs();
        if (|(mask & busy_vec())) begin
            $display("%s: entries still busy after 100 cycles of service", test_name);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = err_cnt + uut.u_chk.fail_cnt;
    endtask

    task automatic end_test();
        int errs;
        errs = err_cnt + uut.u_chk.fail_cnt - errs_at_start;
        if (errs == 0) begin
            pass_tests++;
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errs);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    initial begin
        int e;
        int k;
        foreach (m_state[i]) m_state[i] = S_IDLE;
        ds_ptr  = 0;
        rd_ptr  = 0;
        ds_lock = -1;
        rd_lock = -1;
        rst_n   = 1'b0;
        clear_inputs();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset_state");
        tick();
        check_value("alloc_idx", 0, alloc_idx);
        check_value("stall", 0, stall);
        end_test();

        start_test("alloc_order");
        repeat (N) push_request($random(seed), $random(seed));
        check_value("stall", 1, stall);
        k = $unsigned($random(seed)) % N;
        drain(N'(1) << k);
        check_value("alloc_idx", k, alloc_idx);  // only free entry
        drain('1);
        end_test();

        start_test("miss_path");
        repeat (3) push_request(1'b0, $random(seed));
        repeat (3) tick();  // back-pressure
        ds_req_rdy = 1'b1;
        repeat (3) tick();
        drain('1);
        end_test();

        start_test("linefill_read");
        e = lowest_free();
        push_request(1'b0, $random(seed));
        ds_req_rdy = 1'b1;
        for (int n = 0; n < 20 && m_state[e] != S_WLF; n++) tick();
        ds_req_rdy        = 1'b0;
        linefill_done     = 1'b1;
        linefill_done_idx = e;
        rd_rdy            = ~(4'b1 << m_dir[e]);  // every port but its own
        tick();
        linefill_done = 1'b0;
        check_value("rd_vld", 4'b1 << m_dir[e], rd_vld);
        repeat (3) tick();
        drain('1);
        end_test();

        start_test("hit_path");
        for (int d = 0; d < 4; d++) begin
            push_request(1'b1, 2'(d));
            check_value("ds_req_vld", 0, ds_req_vld);
            check_value("rd_vld", 4'b1 << d, rd_vld);
            tick();  // its port held back
            drain('1);
        end
        end_test();

        start_test("release_timing");
        repeat (4) push_request($random(seed), $random(seed));
        drain('1);
        tick();
        end_test();

        $display("tests passed: %0d, failed: %0d", pass_tests, TEST_NUM - pass_tests);
        if (pass_tests == TEST_NUM && err_cnt + uut.u_chk.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- testbench/mshr_chk.sv
`timescale 1ns/10ps

module mshr_chk (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic                                   alloc_vld,
    input logic                                   stall,
    input logic                                   ds_req_vld,
    input logic                                   ds_req_rdy,
    input logic [mshr_cfg_pkg::ADDR_W-1:0]        ds_req_addr,
    input logic [mshr_cfg_pkg::IDX_W-1:0]         ds_req_idx,
    input logic [3:0]                             rd_vld,  // west at bit 0
    input logic [3:0]                             rd_rdy,
    input logic [3:0][mshr_cfg_pkg::ADDR_W+mshr_cfg_pkg::IDX_W-1:0] rd_pld,
    input logic                                   release_vld,
    input logic [mshr_cfg_pkg::IDX_W-1:0]         release_idx
);

    int fail_cnt = 0;

    a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == !alloc_vld)
        else begin
            $error("stall does not mirror alloc_vld");
            fail_cnt++;
        end

    // ------------------------------
    // handshake hold
    // ------------------------------
    a_ds_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ds_req_vld && !ds_req_rdy |=> ds_req_vld && $stable({ds_req_addr, ds_req_idx}))
        else begin
            $error("downstream request dropped or changed before it was taken");
            fail_cnt++;
        end

    for (genvar d = 0; d < 4; d++) begin : g_dir
        a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
            rd_vld[d] && !rd_rdy[d] |=> rd_vld[d] && $stable(rd_pld[d]))
            else begin
                $error("read command on port %0d dropped or changed before it was taken", d);
                fail_cnt++;
            end
    end

    a_one_dir: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_vld))
        else begin
            $error("more than one direction valid at once");
            fail_cnt++;
        end

    // same index may not release twice in a row
    a_rel_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        release_vld |=> !release_vld || (release_idx != $past(release_idx)))
        else begin
            $error("release_vld held longer than one cycle");
            fail_cnt++;
        end

endmodule

bind mshr_top mshr_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .alloc_vld   (alloc_vld),
    .stall       (stall),
    .ds_req_vld  (ds_req_vld),
    .ds_req_rdy  (ds_req_rdy),
    .ds_req_addr (ds_req_addr),
    .ds_req_idx  (ds_req_idx),
    .rd_vld      ({north_rd_vld, south_rd_vld, east_rd_vld, west_rd_vld}),
    .rd_rdy      ({north_rd_rdy, south_rd_rdy, east_rd_rdy, west_rd_rdy}),
    .rd_pld      ({north_rd_addr, north_rd_idx, south_rd_addr, south_rd_idx,
                   east_rd_addr, east_rd_idx, west_rd_addr, west_rd_idx}),
    .release_vld (release_vld),
    .release_idx (release_idx)
);

//--- hdl/mshr_top.sv
`timescale 1ns/10ps

module mshr_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // tag pipe
    output logic                            alloc_vld,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  alloc_idx,
    output logic                            stall,
    input  logic                            update_en,
    input  logic [mshr_cfg_pkg::IDX_W-1:0]  update_idx,
    input  logic [mshr_cfg_pkg::ADDR_W-1:0] update_addr,
    input  logic [1:0]                      update_dir,
    input  logic                            update_hit,
    // downstream
    output logic                            ds_req_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] ds_req_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  ds_req_idx,
    input  logic                            ds_req_rdy,
    input  logic                            linefill_done,
    input  logic [mshr_cfg_pkg::IDX_W-1:0]  linefill_done_idx,
    // data-RAM read commands
    output logic                            west_rd_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] west_rd_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  west_rd_idx,
    input  logic                            west_rd_rdy,
    output logic                            east_rd_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] east_rd_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  east_rd_idx,
    input  logic                            east_rd_rdy,
    output logic                            south_rd_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] south_rd_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  south_rd_idx,
    input  logic                            south_rd_rdy,
    output logic                            north_rd_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] north_rd_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  north_rd_idx,
    input  logic                            north_rd_rdy,
    // completion and release
    input  logic                            rd_done,
    input  logic [mshr_cfg_pkg::IDX_W-1:0]  rd_done_idx,
    output logic                            release_vld,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  release_idx
);

    mshr_entry_bus_if u_bus ();

    logic [mshr_cfg_pkg::IDX_W-1:0] ds_grant_idx;
    mshr_msg_pkg::ds_req_t          ds_req;

    mshr_entry_table u_table (
        .clk (clk), .rst_n (rst_n),
        .update_en (update_en), .update_idx (update_idx), .update_addr (update_addr),
        .update_dir (mshr_msg_pkg::dir_e'(update_dir)), .update_hit (update_hit),
        .linefill_done (linefill_done), .linefill_done_idx (linefill_done_idx),
        .rd_done (rd_done), .rd_done_idx (rd_done_idx),
        .alloc_vld (alloc_vld), .alloc_idx (alloc_idx), .stall (stall),
        .release_vld (release_vld), .release_idx (release_idx),
        .bus (u_bus.entry_side)
    );

    // miss requests, one winner at a time
    mshr_rr_arb #(
        .REQ_W (mshr_cfg_pkg::ENTRY_NUM)
    ) u_ds_arb (
        .clk (clk), .rst_n (rst_n),
        .req_vld (u_bus.ds_vld), .req_rdy_out (ds_req_rdy), .req_rdy (u_bus.ds_rdy),
        .grant_vld (ds_req_vld), .grant_idx (ds_grant_idx)
    );

    assign ds_req.addr = u_bus.pld[ds_grant_idx].addr;
    assign ds_req.idx  = ds_grant_idx;
    assign ds_req_addr = ds_req.addr;
    assign ds_req_idx  = ds_req.idx;

    mshr_read_router u_rd_router (
        .clk (clk), .rst_n (rst_n),
        .west_rd_rdy (west_rd_rdy), .east_rd_rdy (east_rd_rdy),
        .south_rd_rdy (south_rd_rdy), .north_rd_rdy (north_rd_rdy),
        .bus (u_bus.rd_side),
        .west_rd_vld (west_rd_vld), .west_rd_addr (west_rd_addr), .west_rd_idx (west_rd_idx),
        .east_rd_vld (east_rd_vld), .east_rd_addr (east_rd_addr), .east_rd_idx (east_rd_idx),
        .south_rd_vld (south_rd_vld), .south_rd_addr (south_rd_addr),
        .south_rd_idx (south_rd_idx),
        .north_rd_vld (north_rd_vld), .north_rd_addr (north_rd_addr),
        .north_rd_idx (north_rd_idx)
    );

endmodule

//--- hdl/mshr_read_router.sv
`timescale 1ns/10ps

module mshr_read_router (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            west_rd_rdy,
    input  logic                            east_rd_rdy,
    input  logic                            south_rd_rdy,
    input  logic                            north_rd_rdy,
    mshr_entry_bus_if.rd_side               bus,
    output logic                            west_rd_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] west_rd_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  west_rd_idx,
    output logic                            east_rd_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] east_rd_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  east_rd_idx,
    output logic                            south_rd_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] south_rd_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  south_rd_idx,
    output logic                            north_rd_vld,
    output logic [mshr_cfg_pkg::ADDR_W-1:0] north_rd_addr,
    output logic [mshr_cfg_pkg::IDX_W-1:0]  north_rd_idx
);

    logic                                 grant_vld;
    logic [mshr_cfg_pkg::IDX_W-1:0]       grant_idx;
    mshr_msg_pkg::rd_cmd_t                cmd;
    logic [mshr_cfg_pkg::DIR_NUM-1:0]     dir_vld;
    logic [mshr_cfg_pkg::DIR_NUM-1:0]     dir_rdy;

    assign dir_rdy = {north_rd_rdy, south_rd_rdy, east_rd_rdy, west_rd_rdy};

    mshr_rr_arb #(
        .REQ_W       (mshr_cfg_pkg::ENTRY_NUM)
    ) u_rd_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_vld     (bus.rd_vld),
        .req_rdy_out (dir_rdy[cmd.dir]),  // only the winner's port counts
        .req_rdy     (bus.rd_rdy),
        .grant_vld   (grant_vld),
        .grant_idx   (grant_idx)
    );

    assign cmd.addr = bus.pld[grant_idx].addr;
    assign cmd.dir  = bus.pld[grant_idx].dir;
    assign cmd.idx  = grant_idx;

    // steer to one direction
    always_comb begin
        dir_vld          = '0;
        dir_vld[cmd.dir] = grant_vld;
    end

    assign {north_rd_vld, south_rd_vld, east_rd_vld, west_rd_vld} = dir_vld;

    assign west_rd_addr  = cmd.addr;
    assign west_rd_idx   = cmd.idx;
    assign east_rd_addr  = cmd.addr;
    assign east_rd_idx   = cmd.idx;
    assign south_rd_addr = cmd.addr;
    assign south_rd_idx  = cmd.idx;
    assign north_rd_addr = cmd.addr;
    assign north_rd_idx  = cmd.idx;

endmodule

//--- hdl/mshr_rr_arb.sv
`timescale 1ns/10ps

module mshr_rr_arb #(
    parameter  int unsigned REQ_W = mshr_cfg_pkg::ENTRY_NUM,
    localparam int unsigned PTR_W = (REQ_W > 1) ? $clog2(REQ_W) : 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [REQ_W-1:0] req_vld,
    input  logic             req_rdy_out,
    output logic [REQ_W-1:0] req_rdy,
    output logic             grant_vld,
    output logic [PTR_W-1:0] grant_idx
);

    logic [PTR_W-1:0] ptr;
    logic             lock_vld;  // winner stalled last cycle
    logic [PTR_W-1:0] lock_idx;

    // first requester at or after ptr
    always_comb begin
        int cand;
        grant_vld = 1'b0;
        grant_idx = ptr;
        for (int k = REQ_W - 1; k >= 0; k--) begin
            cand = (int'(ptr) + k) % REQ_W;
            if (req_vld[cand]) begin
                grant_vld = 1'b1;
                grant_idx = cand[PTR_W-1:0];
            end
        end
        if (lock_vld) begin
            // held request keeps the grant until taken
            grant_vld = 1'b1;
            grant_idx = lock_idx;
        end
    end

    always_comb begin
        req_rdy            = '0;
        req_rdy[grant_idx] = grant_vld && req_rdy_out;
    end

    // ------------------------------
    // pointer and lock
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            lock_vld <= 1'b0;
            lock_idx <= '0;
        end else if (grant_vld && req_rdy_out) begin
            ptr      <= (grant_idx == REQ_W - 1) ? '0 : grant_idx + 1'b1;
            lock_vld <= 1'b0;
        end else if (grant_vld) begin
            lock_vld <= 1'b1;
            lock_idx <= grant_idx;
        end
    end

endmodule

//--- hdl/mshr_entry_table.sv
`timescale 1ns/10ps

module mshr_entry_table (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                update_en,
    input  logic [mshr_cfg_pkg::IDX_W-1:0]      update_idx,
    input  logic [mshr_cfg_pkg::ADDR_W-1:0]     update_addr,
    input  mshr_msg_pkg::dir_e                  update_dir,
    input  logic                                update_hit,
    input  logic                                linefill_done,
    input  logic [mshr_cfg_pkg::IDX_W-1:0]      linefill_done_idx,
    input  logic                                rd_done,
    input  logic [mshr_cfg_pkg::IDX_W-1:0]      rd_done_idx,
    output logic                                alloc_vld,
    output logic [mshr_cfg_pkg::IDX_W-1:0]      alloc_idx,
    output logic                                stall,
    output logic                                release_vld,
    output logic [mshr_cfg_pkg::IDX_W-1:0]      release_idx,
    mshr_entry_bus_if.entry_side                bus
);

    logic [mshr_cfg_pkg::ENTRY_NUM-1:0] busy;
    logic [mshr_cfg_pkg::ENTRY_NUM-1:0] release_vec;

    mshr_msg_pkg::entry_pld_t pld_q [mshr_cfg_pkg::ENTRY_NUM];

    // payload store, written into the offered entry
    always_ff @(posedge clk) begin
        if (update_en) begin
            pld_q[update_idx].addr <= update_addr;
            pld_q[update_idx].dir  <= update_dir;
            pld_q[update_idx].hit  <= update_hit;
        end
    end

    assign bus.pld = pld_q;

    // ------------------------------
    // allocation
    // ------------------------------
    always_comb begin
        alloc_idx = '0;
        for (int i = mshr_cfg_pkg::ENTRY_NUM - 1; i >= 0; i--) begin
            if (!busy[i]) alloc_idx = i[mshr_cfg_pkg::IDX_W-1:0];  // lowest wins
        end
    end

    assign alloc_vld = ~&busy;
    assign stall     = &busy;

    // release is one-hot, rd_done has a single index
    always_comb begin
        release_idx = '0;
        for (int i = 0; i < mshr_cfg_pkg::ENTRY_NUM; i++) begin
            if (release_vec[i]) release_idx = i[mshr_cfg_pkg::IDX_W-1:0];
        end
    end

    assign release_vld = |release_vec;

    // ------------------------------
    // entry array
    // ------------------------------
    for (genvar i = 0; i < mshr_cfg_pkg::ENTRY_NUM; i++) begin : g_entry
        mshr_entry #(
            .ENTRY_ID      (i)
        ) u_entry (
            .clk           (clk),
            .rst_n         (rst_n),
            .update_en     (update_en && (update_idx == i)),
            .update_hit    (update_hit),
            .linefill_done (linefill_done && (linefill_done_idx == i)),
            .rd_done       (rd_done && (rd_done_idx == i)),
            .bus           (bus),
            .busy          (busy[i]),
            .release_en    (release_vec[i])
        );
    end

endmodule

//--- hdl/mshr_entry.sv
`timescale 1ns/10ps

module mshr_entry #(
    parameter int unsigned ENTRY_ID = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    update_en,
    input  logic                    update_hit,
    input  logic                    linefill_done,
    input  logic                    rd_done,
    mshr_entry_bus_if.entry_side    bus,
    output logic                    busy,
    output logic                    release_en
);

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_DS_REQ  = 3'd1,
        ST_WAIT_LF = 3'd2,
        ST_RD_REQ  = 3'd3,
        ST_WAIT_RD = 3'd4,
        ST_RELEASE = 3'd5
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   ds_take;
    logic   rd_take;

    assign ds_take = bus.ds_vld[ENTRY_ID] && bus.ds_rdy[ENTRY_ID];
    assign rd_take = bus.rd_vld[ENTRY_ID] && bus.rd_rdy[ENTRY_ID];

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_RELEASE: begin
                // release cycle already counts as free, may be refilled
                if (update_en) begin
                    state_nxt = update_hit ? ST_RD_REQ : ST_DS_REQ;
                end else begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_DS_REQ: begin
                if (ds_take) state_nxt = ST_WAIT_LF;
            end
            ST_WAIT_LF: begin
                if (linefill_done) state_nxt = ST_RD_REQ;
            end
            ST_RD_REQ: begin
                if (rd_take) state_nxt = ST_WAIT_RD;
            end
            ST_WAIT_RD: begin
                if (rd_done) state_nxt = ST_RELEASE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------
    assign bus.ds_vld[ENTRY_ID] = (state == ST_DS_REQ);
    assign bus.rd_vld[ENTRY_ID] = (state == ST_RD_REQ);

    assign busy       = (state != ST_IDLE) && (state != ST_RELEASE);
    assign release_en = (state == ST_RELEASE);  // one cycle only

endmodule

//--- hdl/mshr_entry_bus_if.sv
`timescale 1ns/10ps

interface mshr_entry_bus_if;

    // one bit per entry on every vector
    logic [mshr_cfg_pkg::ENTRY_NUM-1:0] ds_vld;
    logic [mshr_cfg_pkg::ENTRY_NUM-1:0] ds_rdy;
    logic [mshr_cfg_pkg::ENTRY_NUM-1:0] rd_vld;
    logic [mshr_cfg_pkg::ENTRY_NUM-1:0] rd_rdy;

    mshr_msg_pkg::entry_pld_t pld [mshr_cfg_pkg::ENTRY_NUM];  // stored per entry

    // entry array and payload store
    modport entry_side (
        output ds_vld,
        output rd_vld,
        output pld,
        input  ds_rdy,
        input  rd_rdy
    );

    // downstream arbiter
    modport ds_side (
        input  ds_vld,
        input  pld,
        output ds_rdy
    );

    // data-RAM read router
    modport rd_side (
        input  rd_vld,
        input  pld,
        output rd_rdy
    );

endinterface

//--- hdl/mshr_msg_pkg.sv
package mshr_msg_pkg;

    // requesting direction, also picks the read command port
    typedef enum logic [1:0] {
        DIR_WEST  = 2'd0,
        DIR_EAST  = 2'd1,
        DIR_SOUTH = 2'd2,
        DIR_NORTH = 2'd3
    } dir_e;

    // ------------------------------
    // payloads
    // ------------------------------

    // what an entry keeps between update and release
    typedef struct packed {
        logic [mshr_cfg_pkg::ADDR_W-1:0] addr;
        dir_e                            dir;
        logic                            hit;
    } entry_pld_t;

    // miss request towards downstream
    typedef struct packed {
        logic [mshr_cfg_pkg::ADDR_W-1:0] addr;
        logic [mshr_cfg_pkg::IDX_W-1:0]  idx;
    } ds_req_t;

    // data-RAM read command
    typedef struct packed {
        logic [mshr_cfg_pkg::ADDR_W-1:0] addr;
        dir_e                            dir;
        logic [mshr_cfg_pkg::IDX_W-1:0]  idx;
    } rd_cmd_t;

endpackage

//--- hdl/mshr_cfg_pkg.sv
package mshr_cfg_pkg;

    // ------------------------------
    // MSHR sizing
    // ------------------------------

    // entries per cache bank
    localparam int unsigned ENTRY_NUM = 8;

    // entry index width, log2 of ENTRY_NUM
    localparam int unsigned IDX_W = 3;

    // ------------------------------
    // request fields
    // ------------------------------

    localparam int unsigned ADDR_W = 16;  // line address

    // west, east, south, north
    localparam int unsigned DIR_NUM = 4;

endpackage
